//--- verilog/fetchPkg.sv
// Fetch stage 1 shared types
package fetchPkg;

  localparam int FETCH_WIDTH  = 4;  // instructions per fetch bundle.
  localparam int BTB_ENTRIES  = 16; // target buffer entries in each bank.
  localparam int BP_ENTRIES   = 64; // direction counters in each bank.
  localparam int RAS_DEPTH    = 8;  // entries in the return address stack.
  localparam int CACHE_LINES  = 32; // one bundle per line.
  localparam int BUNDLE_BYTES = 16; // bytes fetched per cycle.

  localparam int PC_BITS          = 32;
  localparam int INST_BITS        = 32;
  localparam int INST_BYTES       = INST_BITS / 8;
  localparam int WORD_OFFSET_BITS = $clog2(INST_BYTES);   // byte offset inside a word.
  localparam int OFFSET_BITS      = $clog2(BUNDLE_BYTES); // byte offset inside a bundle.
  localparam int SLOT_BITS        = $clog2(FETCH_WIDTH);  // selects the bank of a slot.
  localparam int BTB_INDEX_BITS   = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_BITS     = PC_BITS - OFFSET_BITS - BTB_INDEX_BITS;
  localparam int BP_INDEX_BITS    = $clog2(BP_ENTRIES);
  localparam int RAS_PTR_BITS     = $clog2(RAS_DEPTH);
  localparam int CACHE_INDEX_BITS = $clog2(CACHE_LINES);
  localparam int CACHE_TAG_BITS   = PC_BITS - OFFSET_BITS - CACHE_INDEX_BITS;

  typedef logic [PC_BITS-1:0]          pcT;
  typedef logic [INST_BITS-1:0]        instT;
  typedef instT [FETCH_WIDTH-1:0]      bundleT; // slot 0 sits at the lowest address.
  typedef logic [SLOT_BITS-1:0]        slotT;
  typedef logic [BTB_INDEX_BITS-1:0]   btbIndexT;
  typedef logic [BTB_TAG_BITS-1:0]     btbTagT;
  typedef logic [BP_INDEX_BITS-1:0]    bpIndexT;
  typedef logic [1:0]                  counterT;
  typedef logic [RAS_PTR_BITS-1:0]     rasPtrT;
  typedef logic [CACHE_INDEX_BITS-1:0] cacheIndexT;
  typedef logic [CACHE_TAG_BITS-1:0]   cacheTagT;

  localparam pcT LINE_MASK = ~pcT'(BUNDLE_BYTES - 1); // clears the bundle offset.

  // Two-bit saturating counter values.
  localparam counterT CNT_STRONG_NT = 2'b00;
  localparam counterT CNT_WEAK_NT   = 2'b01;
  localparam counterT CNT_STRONG_T  = 2'b11;

  typedef enum logic [1:0] {
    BR_RETURN = 2'b00,
    BR_CALL   = 2'b01,
    BR_JUMP   = 2'b10,
    BR_COND   = 2'b11
  } brTypeT;

  typedef struct packed {
    logic   hit;
    brTypeT ctrlType;
    pcT     target;
  } btbLookupT;

  typedef btbLookupT [FETCH_WIDTH-1:0] btbLookupVecT;

  typedef struct packed {
    logic   hit;
    brTypeT ctrlType;
    pcT     target;
    logic   taken;
  } slotPredT;

  typedef slotPredT [FETCH_WIDTH-1:0] slotPredVecT;

  typedef struct packed {
    logic   valid;
    pcT     pc;
    pcT     target;
    brTypeT brType;
    logic   dir;
  } updateT;

  typedef struct packed {
    logic valid;
    pcT   pc;
  } redirectT;

  typedef struct packed {
    logic valid;
    logic isCall;
    pcT   callPc;
    logic isReturn;
    pcT   target;
  } idRedirectT;

endpackage

//--- verilog/branchTargetBuffer.sv
// Banked branch target buffer
module branchTargetBuffer (
  input  logic                   clk,
  input  logic                   reset,
  input  fetchPkg::pcT           pc_i,
  input  fetchPkg::updateT       update_i,
  output fetchPkg::btbLookupVecT lookup_o
);
  import fetchPkg::*;

  logic     validQ  [FETCH_WIDTH][BTB_ENTRIES]; // one valid bit per entry.
  btbTagT   tagQ    [FETCH_WIDTH][BTB_ENTRIES];
  brTypeT   typeQ   [FETCH_WIDTH][BTB_ENTRIES];
  pcT       targetQ [FETCH_WIDTH][BTB_ENTRIES];

  btbIndexT rdIndex;
  btbTagT   rdTag;
  slotT     updBank;
  btbIndexT updIndex;
  btbTagT   updTag;
  logic     updEn;

  assign rdIndex = pc_i[OFFSET_BITS +: BTB_INDEX_BITS]; // all banks share the bundle index.
  assign rdTag   = pc_i[PC_BITS-1 -: BTB_TAG_BITS];

  assign updBank  = update_i.pc[WORD_OFFSET_BITS +: SLOT_BITS]; // the slot picks the bank.
  assign updIndex = update_i.pc[OFFSET_BITS +: BTB_INDEX_BITS];
  assign updTag   = update_i.pc[PC_BITS-1 -: BTB_TAG_BITS];

  // A conditional branch only earns an entry once it has been taken.
  assign updEn = update_i.valid && ((update_i.brType != BR_COND) || update_i.dir);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < FETCH_WIDTH; b++) begin
        for (int e = 0; e < BTB_ENTRIES; e++) begin
          validQ[b][e] <= 1'b0; // the buffer starts empty.
        end
      end
    end else if (updEn) begin
      validQ[updBank][updIndex] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (updEn) begin
      tagQ[updBank][updIndex]    <= updTag;
      typeQ[updBank][updIndex]   <= update_i.brType;
      targetQ[updBank][updIndex] <= update_i.target; // a later update to the entry replaces it.
    end
  end

  // Lookup is combinational so the prediction lines up with the bundle.
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      lookup_o[s].hit      = validQ[s][rdIndex] && (tagQ[s][rdIndex] == rdTag);
      lookup_o[s].ctrlType = typeQ[s][rdIndex];
      lookup_o[s].target   = targetQ[s][rdIndex];
    end
  end

endmodule

//--- verilog/branchPredictor.sv
// Banked bimodal direction predictor
module branchPredictor (
  input  logic                   clk,
  input  logic                   reset,
  input  fetchPkg::pcT           pc_i,
  input  fetchPkg::updateT       update_i,
  output logic [fetchPkg::FETCH_WIDTH-1:0] taken_o
);
  import fetchPkg::*;

  counterT cntQ [FETCH_WIDTH][BP_ENTRIES]; // one saturating counter per entry.

  bpIndexT rdIndex;
  slotT    updBank;
  bpIndexT updIndex;
  counterT updCnt;
  logic    updEn;

  assign rdIndex  = pc_i[OFFSET_BITS +: BP_INDEX_BITS];
  assign updBank  = update_i.pc[WORD_OFFSET_BITS +: SLOT_BITS];
  assign updIndex = update_i.pc[OFFSET_BITS +: BP_INDEX_BITS];
  assign updCnt   = cntQ[updBank][updIndex]; // current value of the counter being trained.
  assign updEn    = update_i.valid && (update_i.brType == BR_COND); // only conditionals train.

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < FETCH_WIDTH; b++) begin
        for (int e = 0; e < BP_ENTRIES; e++) begin
          cntQ[b][e] <= CNT_WEAK_NT; // every branch starts weakly not taken.
        end
      end
    end else if (updEn) begin
      if (update_i.dir && (updCnt != CNT_STRONG_T)) begin
        cntQ[updBank][updIndex] <= updCnt + counterT'(1); // step toward taken.
      end else if (!update_i.dir && (updCnt != CNT_STRONG_NT)) begin
        cntQ[updBank][updIndex] <= updCnt - counterT'(1); // step toward not taken.
      end
    end
  end

  // The upper counter bit is the predicted direction.
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      taken_o[s] = cntQ[s][rdIndex][1];
    end
  end

endmodule

//--- verilog/returnAddressStack.sv
// Circular return address stack
module returnAddressStack (
  input  logic         clk,
  input  logic         reset,
  input  logic         push_i,
  input  fetchPkg::pcT pushAddr_i,
  input  logic         pop_i,
  input  logic         repairPush_i,
  input  fetchPkg::pcT repairPc_i,
  input  logic         repairPop_i,
  output fetchPkg::pcT top_o
);
  import fetchPkg::*;

  pcT     stackQ [RAS_DEPTH];
  rasPtrT topPtrQ; // points at the most recent return address.
  rasPtrT pushPtr;
  rasPtrT popPtr;

  assign pushPtr = topPtrQ + rasPtrT'(1); // wraps, so a full stack loses its oldest entry.
  assign popPtr  = topPtrQ - rasPtrT'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtrQ <= '0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        stackQ[i] <= '0; // an empty stack reads back zero.
      end
    end else if (repairPush_i && repairPop_i) begin
      stackQ[topPtrQ] <= repairPc_i; // a call that is also a return swaps the top.
    end else if (repairPush_i) begin
      topPtrQ         <= pushPtr;
      stackQ[pushPtr] <= repairPc_i; // decode found a call the BTB missed.
    end else if (repairPop_i) begin
      topPtrQ <= popPtr; // decode found a return the BTB missed.
    end else if (push_i) begin
      topPtrQ         <= pushPtr;
      stackQ[pushPtr] <= pushAddr_i;
    end else if (pop_i) begin
      topPtrQ <= popPtr;
    end
  end

  assign top_o = stackQ[topPtrQ];

endmodule

//--- verilog/instCache.sv
// Direct-mapped bundle instruction cache
module instCache (
  input  logic             clk,
  input  logic             reset,
  input  fetchPkg::pcT     pc_i,
  input  logic             missReady_i,
  input  logic             fillValid_i,
  input  fetchPkg::pcT     fillAddr_i,
  input  fetchPkg::bundleT fillLine_i,
  output logic             hit_o,
  output fetchPkg::bundleT bundle_o,
  output logic             missValid_o,
  output fetchPkg::pcT     missAddr_o
);
  import fetchPkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_FILL
  } missStateT;

  logic       validQ [CACHE_LINES];
  cacheTagT   tagQ   [CACHE_LINES];
  bundleT     dataQ  [CACHE_LINES];

  missStateT  stateQ;
  pcT         reqAddrQ; // line address of the outstanding miss.

  cacheIndexT rdIndex;
  cacheTagT   rdTag;
  cacheIndexT fillIndex;
  cacheTagT   fillTag;
  logic       fillMatch;

  assign rdIndex   = pc_i[OFFSET_BITS +: CACHE_INDEX_BITS];
  assign rdTag     = pc_i[PC_BITS-1 -: CACHE_TAG_BITS];
  assign fillIndex = fillAddr_i[OFFSET_BITS +: CACHE_INDEX_BITS];
  assign fillTag   = fillAddr_i[PC_BITS-1 -: CACHE_TAG_BITS];

  assign hit_o    = validQ[rdIndex] && (tagQ[rdIndex] == rdTag);
  assign bundle_o = dataQ[rdIndex];

  // The fill closes the miss only when it returns the requested line.
  assign fillMatch = fillValid_i && ((fillAddr_i & LINE_MASK) == reqAddrQ);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < CACHE_LINES; i++) begin
        validQ[i] <= 1'b0;
      end
    end else if (fillValid_i) begin
      validQ[fillIndex] <= 1'b1; // fills are always accepted.
    end
  end

  always_ff @(posedge clk) begin
    if (fillValid_i) begin
      tagQ[fillIndex]  <= fillTag;
      dataQ[fillIndex] <= fillLine_i;
    end
  end

  // Reset enters REQUEST for line 0 since the PC restarts at 0 on a cold cache.
  always_ff @(posedge clk) begin
    if (reset) begin
      stateQ   <= REQUEST;
      reqAddrQ <= '0;
    end else begin
      case (stateQ)
        IDLE: begin
          if (!hit_o) begin
            stateQ   <= REQUEST;
            reqAddrQ <= pc_i & LINE_MASK; // capture the line so the request holds steady.
          end
        end
        REQUEST: begin
          if (missReady_i) begin
            stateQ <= WAIT_FILL; // memory owns the request now.
          end
        end
        WAIT_FILL: begin
          if (fillMatch) begin
            stateQ <= IDLE; // the line is written on this edge and hits next cycle.
          end
        end
        default: begin
          stateQ <= IDLE;
        end
      endcase
    end
  end

  assign missValid_o = (stateQ == REQUEST);
  assign missAddr_o  = reqAddrQ;

endmodule

//--- verilog/fetchStage1.sv
// Fetch stage 1 top level
module fetchStage1 (
  input  logic                  clk,
  input  logic                  reset,
  input  fetchPkg::redirectT    recover_i,
  input  fetchPkg::redirectT    exception_i,
  input  fetchPkg::redirectT    redirectEx_i,
  input  fetchPkg::idRedirectT  redirectId_i,
  input  fetchPkg::updateT      update_i,
  input  logic                  fetchReady_i,
  input  logic                  missReady_i,
  input  logic                  fillValid_i,
  input  fetchPkg::pcT          fillAddr_i,
  input  fetchPkg::bundleT      fillLine_i,
  output logic                  fetchValid_o,
  output fetchPkg::bundleT      bundle_o,
  output fetchPkg::pcT          pc_o,
  output fetchPkg::slotPredVecT slotPred_o,
  output fetchPkg::pcT          rasTop_o,
  output logic                  missValid_o,
  output fetchPkg::pcT          missAddr_o
);
  import fetchPkg::*;

  pcT                     pcQ;
  pcT                     nextPc;
  logic                   pcEn;
  logic                   cacheHit;
  logic                   transfer;
  btbLookupVecT           btbLookup;
  logic [FETCH_WIDTH-1:0] predTaken;
  logic [FETCH_WIDTH-1:0] slotTaken;
  logic                   anyTaken;
  slotT                   firstSlot;
  brTypeT                 firstType;
  pcT                     rasTop;
  logic                   rasPush;
  logic                   rasPop;
  pcT                     rasPushAddr;
  logic                   repairPush;
  logic                   repairPop;

  branchTargetBuffer branchTargetBuffer_inst (
    .clk      (clk),
    .reset    (reset),
    .pc_i     (pcQ),
    .update_i (update_i),
    .lookup_o (btbLookup)
  );

  branchPredictor branchPredictor_inst (
    .clk      (clk),
    .reset    (reset),
    .pc_i     (pcQ),
    .update_i (update_i),
    .taken_o  (predTaken)
  );

  returnAddressStack returnAddressStack_inst (
    .clk          (clk),
    .reset        (reset),
    .push_i       (rasPush),
    .pushAddr_i   (rasPushAddr),
    .pop_i        (rasPop),
    .repairPush_i (repairPush),
    .repairPc_i   (redirectId_i.callPc),
    .repairPop_i  (repairPop),
    .top_o        (rasTop)
  );

  instCache instCache_inst (
    .clk         (clk),
    .reset       (reset),
    .pc_i        (pcQ),
    .missReady_i (missReady_i),
    .fillValid_i (fillValid_i),
    .fillAddr_i  (fillAddr_i),
    .fillLine_i  (fillLine_i),
    .hit_o       (cacheHit),
    .bundle_o    (bundle_o),
    .missValid_o (missValid_o),
    .missAddr_o  (missAddr_o)
  );

  assign fetchValid_o = cacheHit; // a bundle is offered whenever the PC hits.
  assign transfer     = fetchValid_o && fetchReady_i;

  // A slot redirects fetch on a hit that is unconditional or predicted taken.
  // Scanning from the top down leaves the lowest such slot as the winner.
  always_comb begin
    anyTaken  = 1'b0;
    firstSlot = '0;
    for (int s = FETCH_WIDTH - 1; s >= 0; s--) begin
      slotTaken[s] = btbLookup[s].hit && ((btbLookup[s].ctrlType != BR_COND) || predTaken[s]);
      if (slotTaken[s]) begin
        anyTaken  = 1'b1;
        firstSlot = slotT'(s);
      end
    end
  end

  assign firstType = btbLookup[firstSlot].ctrlType;

  // Returns report the stack top since the BTB target is not meaningful for them.
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slotPred_o[s].hit      = btbLookup[s].hit;
      slotPred_o[s].ctrlType = btbLookup[s].ctrlType;
      slotPred_o[s].target   = (btbLookup[s].ctrlType == BR_RETURN) ? rasTop
                                                                    : btbLookup[s].target;
      slotPred_o[s].taken    = slotTaken[s];
    end
  end

  // The next PC priority runs from recovery down to the sequential bundle.
  always_comb begin
    nextPc      = pcQ + pcT'(BUNDLE_BYTES);
    pcEn        = transfer; // without a redirect the PC only moves when the bundle leaves.
    rasPush     = 1'b0;
    rasPop      = 1'b0;
    repairPush  = 1'b0;
    repairPop   = 1'b0;
    rasPushAddr = pcQ + (pcT'(firstSlot) << WORD_OFFSET_BITS) + pcT'(INST_BYTES);
    if (recover_i.valid) begin
      nextPc = recover_i.pc;
      pcEn   = 1'b1;
    end else if (exception_i.valid) begin
      nextPc = exception_i.pc;
      pcEn   = 1'b1;
    end else if (redirectEx_i.valid) begin
      nextPc = redirectEx_i.pc;
      pcEn   = 1'b1;
    end else if (redirectId_i.valid) begin
      nextPc     = redirectId_i.isReturn ? rasTop : redirectId_i.target;
      pcEn       = 1'b1;
      repairPop  = redirectId_i.isReturn; // the stack is repaired only when decode wins.
      repairPush = redirectId_i.isCall;
    end else if (anyTaken) begin
      nextPc  = (firstType == BR_RETURN) ? rasTop : btbLookup[firstSlot].target;
      rasPop  = transfer && (firstType == BR_RETURN); // a stalled bundle leaves the stack alone.
      rasPush = transfer && (firstType == BR_CALL);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pcQ <= '0;
    end else if (pcEn) begin
      pcQ <= nextPc & LINE_MASK; // fetch is always bundle aligned.
    end
  end

  assign pc_o     = pcQ;
  assign rasTop_o = rasTop;

endmodule

//--- dv/fetchStage1Tests.svh
// Fetch stage 1 directed tests

// Every task starts and ends on a falling edge.
task automatic waitForBundle();
  int cycles;
  cycles = 0;
  while (!fetchValid_o && (cycles < VALID_WAIT)) begin
    @(negedge clk);
    cycles++;
  end
  if (!fetchValid_o) begin
    errorCount++;
    $display("No bundle was offered within %0d cycles at pc %h", VALID_WAIT, pc_o);
  end
endtask

task automatic transferBundle();
  fetchReady_i = 1'b1; // the bundle leaves on the next rising edge.
  @(negedge clk);
  fetchReady_i = 1'b0;
endtask

task automatic steerPc(pcT addr);
  redirectEx_i = '{valid: 1'b1, pc: addr};
  @(negedge clk);
  redirectEx_i = '0;
endtask

task automatic trainBranch(pcT pc, pcT target, brTypeT brType, logic dir);
  update_i = '{valid: 1'b1, pc: pc, target: target, brType: brType, dir: dir};
  @(negedge clk);
  update_i = '0; // the write lands on the edge just passed.
endtask

task automatic applyRedirects(redirectT rec, redirectT exc, redirectT ex, idRedirectT id);
  recover_i    = rec;
  exception_i  = exc;
  redirectEx_i = ex;
  redirectId_i = id;
  @(negedge clk);
  recover_i    = '0;
  exception_i  = '0;
  redirectEx_i = '0;
  redirectId_i = '0;
endtask

task automatic coldMiss();
  checkFlag("fetchValid_o", fetchValid_o, 1'b0);
  checkFlag("missValid_o", missValid_o, 1'b1);
  checkPc("missAddr_o", missAddr_o, '0);
  waitForBundle();
  checkPc("pc_o", pc_o, '0);
  checkBundle("bundle_o", bundle_o, memLine('0));
endtask

task automatic sequentialFetch();
  repeat (3) begin
    @(negedge clk); // stalled, so nothing may move.
    checkFlag("fetchValid_o", fetchValid_o, 1'b1);
    checkPc("pc_o", pc_o, '0);
    checkBundle("bundle_o", bundle_o, memLine('0));
  end
  fetchReady_i = 1'b1;
  for (int i = 0; i < 4; i++) begin
    waitForBundle();
    checkPc("pc_o", pc_o, pcT'(i * 16));
    checkBundle("bundle_o", bundle_o, memLine(pcT'(i * 16)));
    @(negedge clk);
  end
  fetchReady_i = 1'b0;
endtask

task automatic jumpCallReturn();
  pcT jumpBase;
  pcT jumpTarget;
  pcT callBase;
  pcT callTarget;
  jumpBase   = alignPc(nextRandom());
  jumpTarget = alignPc(nextRandom());
  callBase   = alignPc(nextRandom());
  callTarget = alignPc(nextRandom());
  trainBranch(jumpBase + 32'd8, jumpTarget, BR_JUMP, 1'b1); // slot 2.
  steerPc(jumpBase);
  waitForBundle();
  checkPred("slotPred_o[2]", slotPred_o[2], makePred(1'b1, BR_JUMP, jumpTarget, 1'b1));
  transferBundle();
  checkPc("pc_o", pc_o, jumpTarget);
  trainBranch(callBase + 32'd4, callTarget, BR_CALL, 1'b1);  // slot 1.
  trainBranch(callTarget, '0, BR_RETURN, 1'b1);              // slot 0 of the callee.
  steerPc(callBase);
  waitForBundle();
  checkPc("rasTop_o", rasTop_o, '0);
  checkPred("slotPred_o[1]", slotPred_o[1], makePred(1'b1, BR_CALL, callTarget, 1'b1));
  transferBundle();
  checkPc("pc_o", pc_o, callTarget);
  checkPc("rasTop_o", rasTop_o, callBase + 32'd8); // return address follows the call slot.
  waitForBundle();
  checkPred("slotPred_o[0]", slotPred_o[0], makePred(1'b1, BR_RETURN, callBase + 32'd8, 1'b1));
  transferBundle();
  checkPc("pc_o", pc_o, alignPc(callBase + 32'd8));
  checkPc("rasTop_o", rasTop_o, '0);
endtask

task automatic conditionalBranch();
  pcT condBase;
  pcT condTarget;
  pcT ntBase;
  condBase   = alignPc(nextRandom());
  condTarget = alignPc(nextRandom());
  ntBase     = alignPc(nextRandom());
  trainBranch(condBase + 32'd12, condTarget, BR_COND, 1'b1); // counter goes 01 to 10.
  steerPc(condBase);
  waitForBundle();
  checkPred("slotPred_o[3]", slotPred_o[3], makePred(1'b1, BR_COND, condTarget, 1'b1));
  transferBundle();
  checkPc("pc_o", pc_o, condTarget);
  trainBranch(condBase + 32'd12, condTarget, BR_COND, 1'b0);
  trainBranch(condBase + 32'd12, condTarget, BR_COND, 1'b0); // now strongly not taken.
  steerPc(condBase);
  waitForBundle();
  checkPred("slotPred_o[3]", slotPred_o[3], makePred(1'b1, BR_COND, condTarget, 1'b0));
  transferBundle();
  checkPc("pc_o", pc_o, condBase + 32'd16);
  trainBranch(ntBase + 32'd4, nextRandom(), BR_COND, 1'b0);
  steerPc(ntBase);
  waitForBundle();
  checkFlag("slotPred_o[1].hit", slotPred_o[1].hit, 1'b0);
  transferBundle();
  checkPc("pc_o", pc_o, ntBase + 32'd16);
endtask

task automatic redirectPriority();
  redirectT   rec;
  redirectT   exc;
  redirectT   ex;
  idRedirectT id;
  pcT         callPc;
  rec    = '{valid: 1'b1, pc: nextRandom()};
  exc    = '{valid: 1'b1, pc: nextRandom()};
  ex     = '{valid: 1'b1, pc: nextRandom()};
  callPc = nextRandom();
  id     = '{valid: 1'b1, isCall: 1'b0, callPc: '0, isReturn: 1'b0, target: nextRandom()};
  applyRedirects(rec, exc, ex, id); // all of them while stalled.
  checkPc("pc_o", pc_o, alignPc(rec.pc));
  applyRedirects('0, exc, ex, id);
  checkPc("pc_o", pc_o, alignPc(exc.pc));
  id.isCall = 1'b1;
  id.callPc = callPc;
  applyRedirects('0, '0, ex, id);
  checkPc("pc_o", pc_o, alignPc(ex.pc));
  checkPc("rasTop_o", rasTop_o, '0); // a losing decode redirect leaves the stack alone.
  applyRedirects('0, '0, '0, id);
  checkPc("pc_o", pc_o, alignPc(id.target));
  checkPc("rasTop_o", rasTop_o, callPc);
  id.isCall   = 1'b0;
  id.isReturn = 1'b1;
  applyRedirects('0, '0, '0, id);
  checkPc("pc_o", pc_o, alignPc(callPc));
  checkPc("rasTop_o", rasTop_o, '0);
endtask

//--- dv/fetchStage1Tb.sv
// Fetch stage 1 testbench
module fetchStage1Tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fetchPkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 150; // each miss costs about six cycles.
  localparam int VALID_WAIT      = 20;  // the longest wait for a bundle covers two misses.
  localparam pcT MEM_XOR         = 32'h5a5a_c3c3; // memory word is its byte address XOR this.

  logic        clk;
  logic        reset;
  redirectT    recover_i;
  redirectT    exception_i;
  redirectT    redirectEx_i;
  idRedirectT  redirectId_i;
  updateT      update_i;
  logic        fetchReady_i;
  logic        missReady_i;
  logic        fillValid_i;
  pcT          fillAddr_i;
  bundleT      fillLine_i;
  logic        fetchValid_o;
  bundleT      bundle_o;
  pcT          pc_o;
  slotPredVecT slotPred_o;
  pcT          rasTop_o;
  logic        missValid_o;
  pcT          missAddr_o;

  int errorCount = 0;
  int checkCount = 0;
  pcT lcgState   = 32'h9f82928f;
  int fillCount  = 0;  // cycles left until the memory answers.
  pcT acceptAddr = '0; // line address of the accepted miss.

  fetchStage1 fetchStage1_inst (
    .clk          (clk),
    .reset        (reset),
    .recover_i    (recover_i),
    .exception_i  (exception_i),
    .redirectEx_i (redirectEx_i),
    .redirectId_i (redirectId_i),
    .update_i     (update_i),
    .fetchReady_i (fetchReady_i),
    .missReady_i  (missReady_i),
    .fillValid_i  (fillValid_i),
    .fillAddr_i   (fillAddr_i),
    .fillLine_i   (fillLine_i),
    .fetchValid_o (fetchValid_o),
    .bundle_o     (bundle_o),
    .pc_o         (pc_o),
    .slotPred_o   (slotPred_o),
    .rasTop_o     (rasTop_o),
    .missValid_o  (missValid_o),
    .missAddr_o   (missAddr_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // The memory takes a request on the clock edge and sends the fill two cycles later.
  always @(posedge clk) begin
    if (reset) begin
      fillCount <= 0;
    end else if (fillCount != 0) begin
      fillCount <= fillCount - 1;
    end else if (missValid_o && missReady_i) begin
      fillCount  <= 2;
      acceptAddr <= missAddr_o;
    end
  end

  initial begin
    fillValid_i = 1'b0;
    fillAddr_i  = '0;
    fillLine_i  = '0;
    forever begin
      @(negedge clk);
      fillValid_i = (fillCount == 1); // high during the second cycle after acceptance.
      fillAddr_i  = acceptAddr;
      fillLine_i  = memLine(acceptAddr);
    end
  end

  // Ends a run that hangs.
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired before the tests completed after %0d checks", checkCount);
    $display("Some tests failed");
    $finish;
  end

  function automatic bundleT memLine(pcT addr);
    bundleT line;
    for (int w = 0; w < FETCH_WIDTH; w++) begin
      line[w] = ({addr[31:4], 4'h0} + pcT'(w * 4)) ^ MEM_XOR; // slot 0 is the lowest word.
    end
    return line;
  endfunction

  function automatic pcT alignPc(pcT addr);
    return {addr[31:4], 4'h0};
  endfunction

  function automatic pcT nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic slotPredT makePred(logic hit, brTypeT ctrlType, pcT target, logic taken);
    return '{hit: hit, ctrlType: ctrlType, target: target, taken: taken};
  endfunction

  task automatic checkPc(string name, pcT actual, pcT expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic checkBundle(string name, bundleT actual, bundleT expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic checkFlag(string name, logic actual, logic expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic checkPred(string name, slotPredT actual, slotPredT expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  `include "fetchStage1Tests.svh"

  initial begin
    reset        = 1'b1;
    recover_i    = '0;
    exception_i  = '0;
    redirectEx_i = '0;
    redirectId_i = '0;
    update_i     = '0;
    fetchReady_i = 1'b0;
    missReady_i  = 1'b1; // memory always takes a request at once.
    repeat (2) @(negedge clk);
    reset = 1'b0;
    coldMiss();
    sequentialFetch();
    jumpCallReturn();
    conditionalBranch();
    redirectPriority();
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- fetchStage1.f
+incdir+dv
verilog/fetchPkg.sv
verilog/branchTargetBuffer.sv
verilog/branchPredictor.sv
verilog/returnAddressStack.sv
verilog/instCache.sv
verilog/fetchStage1.sv
dv/fetchStage1Tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := fetchStage1Tb
FILELIST  := fetchStage1.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
